// ==== Bender.yml ====
package:
  name: fp_mul

sources:
  # packages first, then the interface and the stages
  - logic/fpFormatPkg.sv
  - logic/fpOpPkg.sv
  - logic/fpStageIf.sv
  - logic/fpDecode.sv
  - logic/fpMantMul.sv
  - logic/fpNormalize.sv
  - logic/fpRound.sv
  - logic/fpMulTop.sv

  - target: simulation
    files:
      - bench/fpMulChecker.sv
      - bench/fpMulTb.sv

// ==== bench/fpMulChecker.sv ====
// result checker for the multiplier testbench
// expectation queue, per-result compare, latency and acceptance spacing checks
// summary counts

`timescale 1ns/1ps

module fpMulChecker #(
  parameter int clkPeriod = 20,
  parameter int latency   = 4
) (
  input logic                 clk,
  input logic                 rstN,
  input logic                 outValid,
  input logic                 outReady,
  input fpFormatPkg::fpWordTy result,
  input fpOpPkg::flagsTy      flags
);

  // --------------------
  // pending expectations
  // --------------------
  fpFormatPkg::fpWordTy expRes[$];
  fpOpPkg::flagsTy      expFlags[$];
  string                expName[$];
  // time of the input handshake for the latency check
  time                  accTime[$];
  bit                   latChk[$];

  // previous checked acceptance for the one-per-cycle check
  time lastAcc  = 0;
  bit  haveLast = 1'b0;

  int passCount = 0;
  int errCount  = 0;

  // called by the driver on every accepted input
  task automatic pushExpect(input fpFormatPkg::fpWordTy res, input fpOpPkg::flagsTy fl,
                            input string nm, input time t, input bit chk);
    // streamed entries go in on consecutive edges
    if (chk && haveLast && (t - lastAcc) != clkPeriod) begin
      noteError($sformatf("%s accepted %0d ns after the previous entry instead of %0d ns",
                          nm, t - lastAcc, clkPeriod));
    end
    haveLast = chk;
    lastAcc  = t;
    expRes.push_back(res);
    expFlags.push_back(fl);
    expName.push_back(nm);
    accTime.push_back(t);
    latChk.push_back(chk);
  endtask

  function automatic int pendingCount();
    return expRes.size();
  endfunction

  // failures that are not a wrong value
  task automatic noteError(input string msg);
    $display("%s", msg);
    errCount++;
  endtask

  // --------------------
  // compare one result
  // --------------------
  task automatic checkOne();
    fpFormatPkg::fpWordTy eRes;
    fpOpPkg::flagsTy      eFl;
    string                nm;
    time                  t0;
    bit                   chk;
    int                   cycles;
    if (expRes.size() == 0) begin
      noteError($sformatf("extra output %h at %0d ns with no input pending", result, $time));
    end else begin
      eRes   = expRes.pop_front();
      eFl    = expFlags.pop_front();
      nm     = expName.pop_front();
      t0     = accTime.pop_front();
      chk    = latChk.pop_front();
      // edges between input and output handshake
      cycles = int'(($time - t0) / clkPeriod);
      if (result !== eRes || flags !== eFl) begin
        $display("ERR %0d ns %s: expected %h flags %b, got %h flags %b",
                 $time, nm, eRes, eFl, result, flags);
        errCount++;
      end else if (chk && cycles != latency) begin
        noteError($sformatf("%s came out %0d cycles after acceptance instead of %0d",
                            nm, cycles, latency));
      end else begin
        $display("ok  %s: %h flags %b", nm, result, flags);
        passCount++;
      end
    end
  endtask

  // one compare per output handshake
  always @(posedge clk) begin
    if (rstN && outValid && outReady) begin
      checkOne();
    end
  end

  task automatic summarize(input int expected);
    $display("results: %0d of %0d correct, %0d errors, %0d still pending",
             passCount, expected, errCount, expRes.size());
  endtask

endmodule

// ==== bench/fpMulTb.sv ====
// testbench top for the single-precision multiplier
// clock, reset, watchdog, stimulus table, driver loop, output ready randomization

`timescale 1ns/1ps

module fpMulTb;

  localparam int clkPeriod   = 20;
  localparam int resetCycles = 8;

  // short names for the rounding modes in the table
  localparam fpOpPkg::rmTy ne = fpOpPkg::rmNearEven;
  localparam fpOpPkg::rmTy rz = fpOpPkg::rmToZero;
  localparam fpOpPkg::rmTy ru = fpOpPkg::rmUp;
  localparam fpOpPkg::rmTy rd = fpOpPkg::rmDown;

  logic                 clk, rstN;
  logic                 inValid, inReady, outValid, outReady;
  fpFormatPkg::fpWordTy a, b, result;
  fpOpPkg::rmTy         rm;
  fpOpPkg::flagsTy      flags;

  // --------------------
  // stimulus table
  // --------------------
  fpFormatPkg::fpWordTy tabA[$], tabB[$], tabRes[$];
  fpOpPkg::rmTy         tabRm[$];
  fpOpPkg::flagsTy      tabFlags[$];
  string                tabName[$];

  logic        tableBuilt;
  logic        randomReady;

  fpMulTop fpMulTop_i (
    .clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady),
    .a(a), .b(b), .rm(rm), .outValid(outValid), .outReady(outReady),
    .result(result), .flags(flags)
  );

  fpMulChecker #(.clkPeriod(clkPeriod), .latency(4)) check_i (
    .clk(clk), .rstN(rstN), .outValid(outValid), .outReady(outReady),
    .result(result), .flags(flags)
  );

  task automatic addEntry(input fpFormatPkg::fpWordTy ea, input fpFormatPkg::fpWordTy eb,
                          input fpOpPkg::rmTy erm, input fpFormatPkg::fpWordTy eres,
                          input fpOpPkg::flagsTy efl, input string nm);
    tabA.push_back(ea);
    tabB.push_back(eb);
    tabRm.push_back(erm);
    tabRes.push_back(eres);
    tabFlags.push_back(efl);
    tabName.push_back(nm);
  endtask

  // flags are {invalid, overflow, underflow, inexact}
  task automatic buildTable();
    // exact products
    addEntry(32'h3FC00000, 32'h40000000, ne, 32'h40400000, 4'b0000, "1.5*2 ne");
    addEntry(32'h3FC00000, 32'h40000000, rz, 32'h40400000, 4'b0000, "1.5*2 rz");
    addEntry(32'h3FC00000, 32'h40000000, ru, 32'h40400000, 4'b0000, "1.5*2 ru");
    addEntry(32'h3FC00000, 32'h40000000, rd, 32'h40400000, 4'b0000, "1.5*2 rd");
    addEntry(32'hC0400000, 32'h3F000000, rz, 32'hBFC00000, 4'b0000, "-3*0.5 rz");
    addEntry(32'h3F800000, 32'h3F800000, rd, 32'h3F800000, 4'b0000, "1*1 rd");
    // guard set, odd lsb, sticky clear
    addEntry(32'h3F800001, 32'h3FC00000, ne, 32'h3FC00002, 4'b0001, "guard odd ne");
    addEntry(32'h3F800001, 32'h3FC00000, rz, 32'h3FC00001, 4'b0001, "guard odd rz");
    addEntry(32'h3F800001, 32'h3FC00000, ru, 32'h3FC00002, 4'b0001, "guard odd ru");
    addEntry(32'h3F800001, 32'h3FC00000, rd, 32'h3FC00001, 4'b0001, "guard odd rd");
    // guard clear, sticky set
    addEntry(32'h3F800001, 32'h3F800001, ne, 32'h3F800002, 4'b0001, "square ne");
    addEntry(32'hBF800001, 32'h3F800001, rd, 32'hBF800003, 4'b0001, "neg square rd");
    addEntry(32'hBF800001, 32'h3F800001, ru, 32'hBF800002, 4'b0001, "neg square ru");
    // special operands
    addEntry(32'h7F800000, 32'h00000000, ne, 32'h7FC00000, 4'b1000, "inf*0");
    addEntry(32'h00400000, 32'hFF800000, rz, 32'h7FC00000, 4'b1000, "denorm*-inf");
    addEntry(32'h7FC12345, 32'h3F800000, ne, 32'h7FC12345, 4'b0000, "qnan a");
    addEntry(32'h7FC00ABC, 32'h7FD00001, ne, 32'h7FC00ABC, 4'b0000, "qnan a wins");
    addEntry(32'h3F800000, 32'hFFC00010, ru, 32'h7FC00010, 4'b0000, "qnan b");
    addEntry(32'h7F800001, 32'h40000000, ne, 32'h7FC00001, 4'b1000, "snan a");
    addEntry(32'h7FC00005, 32'h7F800003, rd, 32'h7FC00005, 4'b1000, "qnan a snan b");
    addEntry(32'h7F800000, 32'hC0000000, ne, 32'hFF800000, 4'b0000, "inf*-2");
    addEntry(32'h80000000, 32'h40A00000, ru, 32'h80000000, 4'b0000, "-0*5");
    addEntry(32'h00000001, 32'hC0000000, ne, 32'h80000000, 4'b0000, "denorm*-2");
    // 2^127 * 4 overflows
    addEntry(32'h7F000000, 32'h40800000, ne, 32'h7F800000, 4'b0101, "ovf ne");
    addEntry(32'h7F000000, 32'h40800000, rz, 32'h7F7FFFFF, 4'b0101, "ovf rz");
    addEntry(32'hFF000000, 32'h40800000, ru, 32'hFF7FFFFF, 4'b0101, "-ovf ru");
    addEntry(32'hFF000000, 32'h40800000, rd, 32'hFF800000, 4'b0101, "-ovf rd");
    // 2^-100 squared flushes and 2.25 * 2^-127 just stays normal
    addEntry(32'h0D800000, 32'h0D800000, ne, 32'h00000000, 4'b0011, "unf");
    addEntry(32'h8D800000, 32'h0D800000, ru, 32'h80000000, 4'b0011, "-unf ru");
    addEntry(32'h20400000, 32'h1FC00000, ne, 32'h00900000, 4'b0000, "min normal edge");
  endtask

  // --------------------
  // driver
  // --------------------
  // holds the entry until inReady and then hands the expectation over
  task automatic sendEntry(input int idx, input bit chkLat);
    a       <= tabA[idx];
    b       <= tabB[idx];
    rm      <= tabRm[idx];
    inValid <= 1'b1;
    @(posedge clk);
    while (!inReady) @(posedge clk);
    check_i.pushExpect(tabRes[idx], tabFlags[idx], tabName[idx], $time, chkLat);
  endtask

  task automatic runPhase(input bit chkLat);
    for (int i = 0; i < tabA.size(); i++) begin
      sendEntry(i, chkLat);
    end
    inValid <= 1'b0;
  endtask

  // queue is only popped on rising edges
  task automatic waitDrain();
    @(negedge clk);
    while (check_i.pendingCount() != 0) @(negedge clk);
    @(posedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // outReady stays high until the random phase and is then high three times in four
  initial begin
    void'($urandom(32'headcf095));
    forever begin
      @(posedge clk);
      if (randomReady) begin
        outReady <= ($urandom % 4) != 0;
      end else begin
        outReady <= 1'b1;
      end
    end
  end

  // watchdog scaled to both passes over the table
  initial begin
    wait (tableBuilt === 1'b1);
    #((tabA.size() * 2 + 8 + 100) * clkPeriod);
    $display("timeout: run did not finish, %0d results never came out",
             check_i.pendingCount());
    $display("** FAIL **");
    $finish;
  end

  initial begin
    rstN        = 1'b0;
    inValid     = 1'b0;
    a           = '0;
    b           = '0;
    rm          = ne;
    outReady    = 1'b1;
    randomReady = 1'b0;
    tableBuilt  = 1'b0;
    buildTable();
    tableBuilt = 1'b1;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    // all slots empty after reset
    if (outValid !== 1'b0 || inReady !== 1'b1) begin
      check_i.noteError("after reset outValid is not low or inReady is not high");
    end
    @(posedge clk);
    // back to back with latency check and then under back-pressure
    runPhase(1'b1);
    waitDrain();
    randomReady <= 1'b1;
    runPhase(1'b0);
    waitDrain();
    // room for any extra output to show up
    repeat (10) @(posedge clk);
    check_i.summarize(2 * tabA.size());
    if (check_i.errCount == 0 && check_i.passCount == 2 * tabA.size()) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== logic/fpDecode.sv ====
// stage 1 of the multiplier
// operand split, classification, sign and exponent sum

`timescale 1ns/1ps

module fpDecode (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 inValid,
  output logic                 inReady,
  input  fpFormatPkg::fpWordTy a,
  input  fpFormatPkg::fpWordTy b,
  input  fpOpPkg::rmTy         rm,
  fpStageIf.src                down
);

  logic                    aSign, bSign;
  fpFormatPkg::expFieldTy  aExp, bExp;
  fpFormatPkg::fracFieldTy aFrac, bFrac;
  logic                    aZero, bZero, aInf, bInf, aNan, bNan;
  logic                    aSnan, bSnan, infZero;
  fpFormatPkg::expIntTy    expSum;
  fpOpPkg::clsTy           clsNext;
  fpFormatPkg::fracFieldTy nanFracNext;

  // --------------------
  // field split
  // --------------------
  assign {aSign, aExp, aFrac} = a;
  assign {bSign, bExp, bFrac} = b;

  // zero exponent covers denormals too, they count as zero
  assign aZero = (aExp == '0);
  assign bZero = (bExp == '0);
  assign aInf  = (aExp == fpFormatPkg::expAllOnes) && (aFrac == '0);
  assign bInf  = (bExp == fpFormatPkg::expAllOnes) && (bFrac == '0);
  assign aNan  = (aExp == fpFormatPkg::expAllOnes) && (aFrac != '0);
  assign bNan  = (bExp == fpFormatPkg::expAllOnes) && (bFrac != '0);
  // signaling NaN has the quiet bit clear
  assign aSnan = aNan && !aFrac[fpFormatPkg::fracWidth-1];
  assign bSnan = bNan && !bFrac[fpFormatPkg::fracWidth-1];

  assign infZero = (aInf && bZero) || (bInf && aZero);

  // biased sum, one bias removed, range -125..381
  assign expSum = fpFormatPkg::expIntTy'(aExp) + fpFormatPkg::expIntTy'(bExp)
                - fpFormatPkg::expIntTy'(fpFormatPkg::expBias);

  // --------------------
  // class and NaN payload
  // --------------------
  always_comb begin
    if (aNan || bNan || infZero) begin
      clsNext = fpOpPkg::clsNan;
    end else if (aInf || bInf) begin
      clsNext = fpOpPkg::clsInf;
    end else if (aZero || bZero) begin
      clsNext = fpOpPkg::clsZero;
    end else begin
      clsNext = fpOpPkg::clsNormal;
    end
  end

  // operand a wins, payload is returned with the quiet bit forced
  always_comb begin
    if (aNan) begin
      nanFracNext = {1'b1, aFrac[fpFormatPkg::fracWidth-2:0]};
    end else if (bNan) begin
      nanFracNext = {1'b1, bFrac[fpFormatPkg::fracWidth-2:0]};
    end else begin
      nanFracNext = fpFormatPkg::qNanDefault[fpFormatPkg::fracWidth-1:0];
    end
  end

  // --------------------
  // output slot
  // --------------------
  // slot frees when empty or when downstream takes it this edge
  assign inReady = !down.valid || down.ready;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      down.valid <= 1'b0;
    end else if (inReady) begin
      down.valid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      down.sign    <= aSign ^ bSign;
      down.exp     <= expSum;
      // significands side by side, hidden bit set
      down.prod    <= {1'b1, aFrac, 1'b1, bFrac};
      down.cls     <= clsNext;
      down.nanFrac <= nanFracNext;
      down.invalid <= infZero || aSnan || bSnan;
      down.rm      <= rm;
    end
  end

endmodule

// ==== logic/fpFormatPkg.sv ====
// single-precision format description
// widths, exponent bias, field and internal typedefs, special encodings

package fpFormatPkg;

  // --------------------
  // format widths
  // --------------------
  localparam int fpWidth   = 32;
  localparam int expWidth  = 8;
  localparam int fracWidth = 23;

  // significand with hidden bit, and the full product of two of them
  localparam int sigWidth  = fracWidth + 1;
  localparam int prodWidth = 2 * sigWidth;

  // internal exponent keeps two extra bits: sign plus headroom above 255
  localparam int expIntWidth = expWidth + 2;

  // exponent offset
  localparam int expBias = 127;

  // --------------------
  // vector types
  // --------------------
  typedef logic [fpWidth-1:0]   fpWordTy;
  typedef logic [expWidth-1:0]  expFieldTy;
  typedef logic [fracWidth-1:0] fracFieldTy;
  typedef logic [sigWidth-1:0]  sigTy;
  typedef logic [prodWidth-1:0] prodTy;

  // biased exponent that may leave the 1..254 range before packing
  typedef logic signed [expIntWidth-1:0] expIntTy;

  // --------------------
  // special encodings
  // --------------------
  // default quiet NaN, returned for inf * 0
  localparam fpWordTy qNanDefault = 32'h7FC0_0000;

  // exponent field of inf and NaN
  localparam expFieldTy expAllOnes = '1;

endpackage

// ==== logic/fpMantMul.sv ====
// stage 2 of the multiplier
// 24x24 significand product, one register

`timescale 1ns/1ps

module fpMantMul (
  input logic   clk,
  input logic   rstN,
  fpStageIf.dst up,
  fpStageIf.src down
);

  fpFormatPkg::sigTy  aSig, bSig;
  fpFormatPkg::prodTy prodNext;

  // a sits in the upper half of the link, b in the lower
  assign {aSig, bSig} = up.prod;

  // full-width product, operands widened by the assignment context
  assign prodNext = aSig * bSig;

  // --------------------
  // output slot
  // --------------------
  assign up.ready = !down.valid || down.ready;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      down.valid <= 1'b0;
    end else if (up.ready) begin
      down.valid <= up.valid;
    end
  end

  // everything except the significands rides along untouched
  always_ff @(posedge clk) begin
    if (up.valid && up.ready) begin
      down.prod    <= prodNext;
      down.sign    <= up.sign;
      down.exp     <= up.exp;
      down.cls     <= up.cls;
      down.nanFrac <= up.nanFrac;
      down.invalid <= up.invalid;
      down.rm      <= up.rm;
    end
  end

endmodule

// ==== logic/fpMulTop.sv ====
// single-precision multiplier top level
// four pipeline stages linked by three stage interfaces

`timescale 1ns/1ps

module fpMulTop (
  input  logic                 clk,
  input  logic                 rstN,
  // operand stream
  input  logic                 inValid,
  output logic                 inReady,
  input  fpFormatPkg::fpWordTy a,
  input  fpFormatPkg::fpWordTy b,
  input  fpOpPkg::rmTy         rm,
  // result stream
  output logic                 outValid,
  input  logic                 outReady,
  output fpFormatPkg::fpWordTy result,
  output fpOpPkg::flagsTy      flags
);

  // --------------------
  // stage links
  // --------------------
  // decode -> multiply, prod holds both significands
  fpStageIf s1 ();
  // multiply -> normalize, prod holds the full product
  fpStageIf s2 ();
  // normalize -> round, prod holds sig, guard, sticky
  fpStageIf s3 ();

  // --------------------
  // stages
  // --------------------
  fpDecode decode_i (
    .clk     (clk),
    .rstN    (rstN),
    .inValid (inValid),
    .inReady (inReady),
    .a       (a),
    .b       (b),
    .rm      (rm),
    .down    (s1.src)
  );

  fpMantMul mantMul_i (
    .clk  (clk),
    .rstN (rstN),
    .up   (s1.dst),
    .down (s2.src)
  );

  fpNormalize normalize_i (
    .clk  (clk),
    .rstN (rstN),
    .up   (s2.dst),
    .down (s3.src)
  );

  fpRound round_i (
    .clk      (clk),
    .rstN     (rstN),
    .up       (s3.dst),
    .outValid (outValid),
    .outReady (outReady),
    .result   (result),
    .flags    (flags)
  );

endmodule

// ==== logic/fpNormalize.sv ====
// stage 3 of the multiplier
// product alignment, exponent adjust, guard and sticky reduction

`timescale 1ns/1ps

module fpNormalize (
  input logic   clk,
  input logic   rstN,
  fpStageIf.dst up,
  fpStageIf.src down
);

  localparam int pw = fpFormatPkg::prodWidth;
  localparam int sw = fpFormatPkg::sigWidth;

  logic                 hiBit;
  fpFormatPkg::sigTy    sigNext;
  logic                 guardNext;
  logic                 stickyNext;
  fpFormatPkg::expIntTy expNext;

  // product of two 1.x values lies in [1, 4), so the msb is bit 47 or 46
  assign hiBit = up.prod[pw-1];

  // --------------------
  // alignment
  // --------------------
  always_comb begin
    if (hiBit) begin
      // 1x.xxx case, shift right by one and bump the exponent
      sigNext    = up.prod[pw-1 -: sw];
      guardNext  = up.prod[pw-sw-1];
      stickyNext = |up.prod[pw-sw-2:0];
      expNext    = up.exp + fpFormatPkg::expIntTy'(1);
    end else begin
      sigNext    = up.prod[pw-2 -: sw];
      guardNext  = up.prod[pw-sw-2];
      stickyNext = |up.prod[pw-sw-3:0];
      expNext    = up.exp;
    end
  end

  // --------------------
  // output slot
  // --------------------
  assign up.ready = !down.valid || down.ready;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      down.valid <= 1'b0;
    end else if (up.ready) begin
      down.valid <= up.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (up.valid && up.ready) begin
      // reduced form: significand, guard, sticky, zeros below
      down.prod    <= {sigNext, guardNext, stickyNext, {(pw-sw-2){1'b0}}};
      down.exp     <= expNext;
      down.sign    <= up.sign;
      down.cls     <= up.cls;
      down.nanFrac <= up.nanFrac;
      down.invalid <= up.invalid;
      down.rm      <= up.rm;
    end
  end

endmodule

// ==== logic/fpOpPkg.sv ====
// operation-level codes for the multiplier
// rounding modes, result classes, exception flag positions

package fpOpPkg;

  // --------------------
  // rounding modes
  // --------------------
  typedef logic [1:0] rmTy;

  // round to nearest, ties to even
  localparam rmTy rmNearEven = 2'd0;
  // truncate
  localparam rmTy rmToZero   = 2'd1;
  // toward +inf
  localparam rmTy rmUp       = 2'd2;
  // toward -inf
  localparam rmTy rmDown     = 2'd3;

  // --------------------
  // result classes
  // --------------------
  typedef logic [1:0] clsTy;

  localparam clsTy clsNormal = 2'd0;
  localparam clsTy clsZero   = 2'd1;
  localparam clsTy clsInf    = 2'd2;
  localparam clsTy clsNan    = 2'd3;

  // --------------------
  // exception flags
  // --------------------
  // msb first: invalid, overflow, underflow, inexact
  typedef logic [3:0] flagsTy;

  localparam int flagInvalid   = 3;
  localparam int flagOverflow  = 2;
  localparam int flagUnderflow = 1;
  localparam int flagInexact   = 0;

endpackage

// ==== logic/fpRound.sv ====
// stage 4 of the multiplier
// rounding, overflow and flush-to-zero, special results, packing and flags

`timescale 1ns/1ps

module fpRound (
  input  logic                 clk,
  input  logic                 rstN,
  fpStageIf.dst                up,
  output logic                 outValid,
  input  logic                 outReady,
  output fpFormatPkg::fpWordTy result,
  output fpOpPkg::flagsTy      flags
);

  localparam int pw = fpFormatPkg::prodWidth;
  localparam int sw = fpFormatPkg::sigWidth;
  localparam int fw = fpFormatPkg::fracWidth;

  fpFormatPkg::sigTy    sig;
  logic                 guard, sticky, inexact, incr, towardZero;
  logic [sw:0]          sigRnd;
  fpFormatPkg::expIntTy expRnd;
  fpFormatPkg::fpWordTy resNext;
  fpOpPkg::flagsTy      flagsNext;

  // reduced form from normalize
  assign sig     = up.prod[pw-1 -: sw];
  assign guard   = up.prod[pw-sw-1];
  assign sticky  = up.prod[pw-sw-2];
  assign inexact = guard | sticky;

  // --------------------
  // rounding increment
  // --------------------
  always_comb begin
    incr = 1'b0;
    case (up.rm)
      fpOpPkg::rmNearEven: incr = guard & (sticky | sig[0]);
      fpOpPkg::rmToZero:   incr = 1'b0;
      fpOpPkg::rmUp:       incr = !up.sign & inexact;
      fpOpPkg::rmDown:     incr = up.sign & inexact;
    endcase
  end

  // on carry out the significand is 1.000.. again, low bits already zero
  assign sigRnd = {1'b0, sig} + (sw+1)'(incr);
  assign expRnd = up.exp + fpFormatPkg::expIntTy'(sigRnd[sw]);

  // modes whose direction points at zero saturate instead of going to inf
  assign towardZero = (up.rm == fpOpPkg::rmToZero)
                   || ((up.rm == fpOpPkg::rmUp) && up.sign)
                   || ((up.rm == fpOpPkg::rmDown) && !up.sign);

  // --------------------
  // packing
  // --------------------
  always_comb begin
    resNext   = '0;
    flagsNext = '0;
    flagsNext[fpOpPkg::flagInvalid] = up.invalid;
    case (up.cls)
      fpOpPkg::clsNan: begin
        resNext = {1'b0, fpFormatPkg::expAllOnes, up.nanFrac};
      end
      fpOpPkg::clsInf: begin
        resNext = {up.sign, fpFormatPkg::expAllOnes, {fw{1'b0}}};
      end
      fpOpPkg::clsZero: begin
        resNext = {up.sign, {(fpFormatPkg::fpWidth-1){1'b0}}};
      end
      default: begin
        if (up.exp <= 0) begin
          // too small for a normal, flushed to signed zero
          resNext = {up.sign, {(fpFormatPkg::fpWidth-1){1'b0}}};
          flagsNext[fpOpPkg::flagUnderflow] = 1'b1;
          flagsNext[fpOpPkg::flagInexact]   = 1'b1;
        end else if (expRnd >= fpFormatPkg::expIntTy'(fpFormatPkg::expAllOnes)) begin
          // overflow, inf or largest finite depending on direction
          if (towardZero) begin
            resNext = {up.sign, fpFormatPkg::expFieldTy'(fpFormatPkg::expAllOnes - 1'b1),
                       {fw{1'b1}}};
          end else begin
            resNext = {up.sign, fpFormatPkg::expAllOnes, {fw{1'b0}}};
          end
          flagsNext[fpOpPkg::flagOverflow] = 1'b1;
          flagsNext[fpOpPkg::flagInexact]  = 1'b1;
        end else begin
          resNext = {up.sign, expRnd[fpFormatPkg::expWidth-1:0], sigRnd[fw-1:0]};
          flagsNext[fpOpPkg::flagInexact] = inexact;
        end
      end
    endcase
  end

  // --------------------
  // output slot
  // --------------------
  assign up.ready = !outValid || outReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else if (up.ready) begin
      outValid <= up.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (up.valid && up.ready) begin
      result <= resNext;
      flags  <= flagsNext;
    end
  end

endmodule

// ==== logic/fpStageIf.sv ====
// stage-to-stage link of the multiplier pipeline
// valid/ready handshake plus the in-flight operation fields

`timescale 1ns/1ps

interface fpStageIf;

  // handshake
  logic valid;
  logic ready;

  // --------------------
  // payload
  // --------------------
  // result sign, already a xor b
  logic                  sign;
  // biased exponent, may be out of range
  fpFormatPkg::expIntTy  exp;
  // significands, product or reduced form, depending on the link
  fpFormatPkg::prodTy    prod;
  // class decided at decode
  fpOpPkg::clsTy         cls;
  // quiet NaN fraction to return when cls is NaN
  fpFormatPkg::fracFieldTy nanFrac;
  // invalid operation seen at decode
  logic                  invalid;
  // rounding mode travels with the pair
  fpOpPkg::rmTy          rm;

  // producer side owns the payload and valid
  modport src (
    output valid, sign, exp, prod, cls, nanFrac, invalid, rm,
    input  ready
  );

  // consumer side only answers with ready
  modport dst (
    input  valid, sign, exp, prod, cls, nanFrac, invalid, rm,
    output ready
  );

endinterface

// ==== tb.f ====
logic/fpFormatPkg.sv
logic/fpOpPkg.sv
logic/fpStageIf.sv
logic/fpDecode.sv
logic/fpMantMul.sv
logic/fpNormalize.sv
logic/fpRound.sv
logic/fpMulTop.sv
bench/fpMulChecker.sv
bench/fpMulTb.sv
